/* dsp_core.f */
+incdir+dv
common/dsp_cfg_pkg.sv
common/dsp_isa_pkg.sv
rtl/block_store.sv
rtl/block_regfile.sv
rtl/channel_file.sv
pipeline/fetch_decode_stage.sv
pipeline/operand_fetch_stage.sv
pipeline/madd_pipeline.sv
rtl/dsp_core.sv
dv/tb_dsp_core.sv

/* Makefile */
TOP = tb_dsp_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f dsp_core.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* dv/dsp_ref_model.svh */
`ifndef DSP_REF_MODEL_SVH
`define DSP_REF_MODEL_SVH

// Expected state of the core, updated alongside every command sent to it
sample_t ref_chan [16];
instr_t ref_instr [n_blocks_tb];
sample_t ref_active [2][n_blocks_tb];
sample_t ref_shadow [2][n_blocks_tb];
int ref_running;

// (a * b) >>> shift + c, then saturate or wrap to 16 bits
function automatic sample_t madd_result(input sample_t a, input sample_t b, input sample_t c,
		input logic [4:0] shift, input logic wrap);
	logic signed [39:0] wa;
	logic signed [39:0] wb;
	logic signed [39:0] wc;
	logic signed [39:0] sum;
	sample_t result;
	wa = a;
	wb = b;
	wc = c;
	sum = ((wa * wb) >>> shift) + wc;
	result = sum[15:0];
	if (!wrap && sum > 40'sd32767) begin
		result = 16'sh7fff;
	end else if (!wrap && sum < -40'sd32768) begin
		result = 16'sh8000;
	end
	return result;
endfunction

task automatic sweep_program();
	for (int i = 0; i < 16; i++) begin
		ref_chan[i] = '0;
	end
	for (int i = 0; i < n_blocks_tb; i++) begin
		ref_instr[i] = '0;
	end
	ref_running = 0;
endtask

task automatic clear_model_state();
	sweep_program();
	for (int i = 0; i < n_blocks_tb; i++) begin
		for (int s = 0; s < 2; s++) begin
			ref_active[s][i] = '0;
			ref_shadow[s][i] = '0;
		end
	end
endtask

task automatic store_instr(input int addr, input instr_t val);
	ref_instr[addr] = val;
	if (addr >= ref_running) begin
		ref_running = addr + 1;
	end
endtask

task automatic store_reg(input int addr, input int sel, input sample_t val);
	ref_shadow[sel][addr] = val;
endtask

// Only blocks below the running count are copied back into the shadow bank
task automatic swap_banks();
	sample_t held;
	for (int s = 0; s < 2; s++) begin
		for (int i = 0; i < n_blocks_tb; i++) begin
			held = ref_active[s][i];
			ref_active[s][i] = ref_shadow[s][i];
			ref_shadow[s][i] = (i < ref_running) ? ref_active[s][i] : held;
		end
	end
endtask

task automatic run_program();
	instr_t ins;
	sample_t a;
	sample_t b;
	sample_t c;
	for (int i = 0; i < ref_running; i++) begin
		ins = ref_instr[i];
		a = ins[16] ? ref_active[0][i] : ref_chan[ins[3:0]];
		b = ins[17] ? ref_active[1][i] : ref_chan[ins[7:4]];
		c = ref_chan[ins[11:8]];
		ref_chan[ins[15:12]] = madd_result(a, b, c, ins[22:18], ins[23]);
	end
endtask

task automatic exchange_sample(input sample_t val, output sample_t expected);
	expected = ref_chan[0];
	ref_chan[0] = val;
	run_program();
endtask

`endif

/* dv/tb_dsp_core.sv */
module tb_dsp_core;
	timeunit 1ns;
	timeprecision 1ps;

	import dsp_cfg_pkg::*;

	localparam int n_blocks_tb = 16;
	localparam int wait_limit = 4000;

	logic clk;
	logic reset;
	logic tick;
	sample_t sample_in;
	sample_t sample_out;
	logic command_instr_write;
	logic command_reg_write;
	logic [3:0] command_block_target;
	logic command_reg_target;
	instr_t command_instr_write_val;
	sample_t command_reg_write_val;
	logic reg_writes_commit;
	logic full_reset;
	logic ready;
	logic busy;
	logic regfile_syncing;

	logic check_sample;
	sample_t expected_sample;
	logic check_idle;
	logic check_ready_len;
	int ready_low_cycles;
	int errors;
	int checks;
	int tests;
	int mark;

	`include "dsp_ref_model.svh"

	dsp_core #(.data_width(16), .n_blocks(n_blocks_tb)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	a_sample: assert property (@(posedge clk) disable iff (reset)
		check_sample |-> sample_out == expected_sample)
		else begin
			errors++;
			$display("CHECK FAILED sample_out expected %h got %h",
				expected_sample, $sampled(sample_out));
		end

	a_idle: assert property (@(posedge clk) disable iff (reset)
		check_idle |-> !busy && ready && !regfile_syncing && sample_out == '0)
		else begin
			errors++;
			$display("CHECK FAILED after reset busy %h ready %h regfile_syncing %h sample_out %h",
				$sampled(busy), $sampled(ready), $sampled(regfile_syncing),
				$sampled(sample_out));
		end

	a_ready_len: assert property (@(posedge clk) disable iff (reset)
		check_ready_len |-> ready_low_cycles == n_blocks_tb)
		else begin
			errors++;
			$display("CHECK FAILED ready low cycles expected %h got %h",
				n_blocks_tb, ready_low_cycles);
		end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (busy && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			abort_run("Timed out waiting for busy to fall");
		end
	endtask

	task automatic wait_cmd_ready();
		int n;
		n = 0;
		while ((!ready || regfile_syncing) && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!ready || regfile_syncing) begin
			abort_run("Timed out waiting for ready high and regfile_syncing low");
		end
	endtask

	function automatic instr_t make_instr(input int src_a, input int src_b, input int src_c,
			input int dest, input int a_reg, input int b_reg, input int shift, input int wrap);
		return {8'h00, 1'(wrap), 5'(shift), 1'(b_reg), 1'(a_reg),
			4'(dest), 4'(src_c), 4'(src_b), 4'(src_a)};
	endfunction

	function automatic sample_t small_value();
		int v;
		v = int'($urandom_range(255)) - 128;
		return sample_t'(v);
	endfunction

	task automatic write_instr(input int addr, input instr_t val);
		wait_cmd_ready();
		command_instr_write = 1'b1;
		command_block_target = 4'(addr);
		command_instr_write_val = val;
		@(negedge clk);
		command_instr_write = 1'b0;
		store_instr(addr, val);
	endtask

	task automatic write_reg(input int addr, input int sel, input sample_t val);
		wait_cmd_ready();
		command_reg_write = 1'b1;
		command_block_target = 4'(addr);
		command_reg_target = 1'(sel);
		command_reg_write_val = val;
		@(negedge clk);
		command_reg_write = 1'b0;
		store_reg(addr, sel, val);
	endtask

	task automatic commit_regs();
		wait_cmd_ready();
		reg_writes_commit = 1'b1;
		@(negedge clk);
		reg_writes_commit = 1'b0;
		swap_banks();
		wait_cmd_ready();
	endtask

	// Output is checked in the cycle after the exchange, then the program runs out
	task automatic send_tick(input sample_t val);
		sample_t expected;
		wait_not_busy();
		tick = 1'b1;
		sample_in = val;
		exchange_sample(val, expected);
		@(negedge clk);
		tick = 1'b0;
		expected_sample = expected;
		check_sample = 1'b1;
		checks++;
		@(negedge clk);
		check_sample = 1'b0;
		wait_not_busy();
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("%s done, %0d errors", name, errors - mark);
		mark = errors;
	endtask

	initial begin
		void'($urandom(32'he4ab));
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		command_instr_write = 1'b0;
		command_reg_write = 1'b0;
		command_block_target = '0;
		command_reg_target = 1'b0;
		command_instr_write_val = '0;
		command_reg_write_val = '0;
		reg_writes_commit = 1'b0;
		full_reset = 1'b0;
		check_sample = 1'b0;
		expected_sample = '0;
		check_idle = 1'b0;
		check_ready_len = 1'b0;
		ready_low_cycles = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		mark = 0;
		clear_model_state();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		check_idle = 1'b1;
		checks++;
		@(negedge clk);
		check_idle = 1'b0;

		repeat (8) send_tick(sample_t'($urandom));
		report_test("pass_through");

		// Blocks 0 to 2 load channels 1 to 3 from registers, block 4 copies channel 4 out
		write_instr(0, make_instr(0, 0, 15, 1, 1, 1, 0, 0));
		write_instr(1, make_instr(0, 0, 15, 2, 1, 1, 0, 0));
		write_instr(2, make_instr(0, 0, 15, 3, 1, 1, 0, 0));
		write_instr(4, make_instr(0, 4, 15, 0, 1, 0, 0, 0));
		write_reg(4, 0, 16'sd1);
		for (int i = 0; i < 12; i++) begin
			for (int b = 0; b < 3; b++) begin
				write_reg(b, 0, sample_t'($urandom));
				write_reg(b, 1, 16'sd1);
			end
			commit_regs();
			// Junk in the top byte must not matter
			write_instr(3, make_instr(1, 2, 3, 4, 0, 0, $urandom_range(31), $urandom_range(1))
				| {8'($urandom), 24'h0});
			repeat (2) send_tick(sample_t'($urandom));
		end
		report_test("madd_rule");

		for (int b = 0; b < 7; b++) begin
			write_instr(b, make_instr(b, $urandom_range(15), b, b + 1, 0, 1,
				$urandom_range(15), $urandom_range(1)));
		end
		write_instr(7, make_instr(0, 7, 15, 0, 1, 0, 0, 0));
		for (int r = 0; r < 2; r++) begin
			for (int b = 0; b < 7; b++) begin
				write_reg(b, 1, sample_t'($urandom));
			end
			write_reg(7, 0, 16'sd1);
			commit_regs();
			repeat (4) send_tick(sample_t'($urandom));
		end
		report_test("dependent_chain");

		write_instr(7, make_instr(15, 15, 15, 0, 1, 1, 0, 0));
		write_reg(7, 0, small_value());
		write_reg(7, 1, small_value());
		commit_regs();
		repeat (2) send_tick(sample_t'($urandom));
		// Shadow edits stay hidden until the commit
		write_reg(7, 0, small_value());
		write_reg(7, 1, small_value());
		repeat (2) send_tick(sample_t'($urandom));
		commit_regs();
		repeat (2) send_tick(sample_t'($urandom));
		write_reg(7, 1, small_value());
		commit_regs();
		repeat (2) send_tick(sample_t'($urandom));
		report_test("register_commit");

		wait_cmd_ready();
		full_reset = 1'b1;
		@(negedge clk);
		full_reset = 1'b0;
		sweep_program();
		ready_low_cycles = 0;
		while (!ready && ready_low_cycles < wait_limit) begin
			ready_low_cycles++;
			@(negedge clk);
		end
		if (!ready) begin
			abort_run("Timed out waiting for ready to return after full_reset");
		end
		check_ready_len = 1'b1;
		checks++;
		@(negedge clk);
		check_ready_len = 1'b0;
		repeat (4) send_tick(sample_t'($urandom));
		// Every channel read here was cleared by the sweep
		write_instr(0, make_instr(3, 9, 12, 1, 0, 0, 0, 0));
		write_instr(1, make_instr(5, 7, 1, 0, 0, 0, 0, 0));
		repeat (3) send_tick(sample_t'($urandom));
		report_test("full_reset");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* rtl/dsp_core.sv */
module dsp_core #(
	parameter int data_width = dsp_cfg_pkg::DATA_W,
	parameter int n_blocks = dsp_cfg_pkg::N_BLOCKS_DEF,
	localparam type block_addr_t = logic [$clog2(n_blocks)-1:0]
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input dsp_cfg_pkg::sample_t sample_in,
	output dsp_cfg_pkg::sample_t sample_out,
	input logic command_instr_write,
	input logic command_reg_write,
	input block_addr_t command_block_target,
	input logic command_reg_target,
	input dsp_cfg_pkg::instr_t command_instr_write_val,
	input dsp_cfg_pkg::sample_t command_reg_write_val,
	input logic reg_writes_commit,
	input logic full_reset,
	output logic ready,
	output logic busy,
	output logic regfile_syncing
);
	import dsp_cfg_pkg::*;
	import dsp_isa_pkg::*;

	typedef logic [$clog2(n_blocks):0] block_count_t;

	block_count_t n_blocks_running;
	block_addr_t block_read_addr;
	instr_t instr_read_val;
	logic sweeping;
	sample_t register_0_out, register_1_out;

	// Fetch/decode to operand fetch
	logic dec_valid, dec_ready;
	chan_addr_t dec_src_a, dec_src_b, dec_src_c, dec_dest;
	logic dec_a_is_reg, dec_b_is_reg, dec_sat_disable;
	shift_t dec_shift;
	sample_t dec_register_0, dec_register_1;

	// Operand fetch to the multiply-add pipeline
	chan_addr_t read_addr_a, read_addr_b, read_addr_c, dest;
	sample_t read_a, read_b, read_c;
	logic issue_valid, issue_ready, sat_disable;
	sample_t arg_a, arg_b, arg_c;
	shift_t shift;

	// Channel write-back
	logic write_enable, wb_done;
	chan_addr_t write_addr, wb_dest;
	sample_t write_val;

	block_store #(.n_blocks(n_blocks)) u_block_store (
		.*,
		.instr_write(command_instr_write),
		.write_addr(command_block_target),
		.write_val(command_instr_write_val),
		.read_addr(block_read_addr),
		.read_val(instr_read_val)
	);

	block_regfile #(.n_blocks(n_blocks)) u_block_regfile (
		.clk(clk),
		.reset(reset),
		.n_active_blocks(n_blocks_running),
		.read_addr(block_read_addr),
		.write_addr(command_block_target),
		.write_select(command_reg_target),
		.write_value(command_reg_write_val),
		.write_enable(command_reg_write),
		.commit(reg_writes_commit),
		.register_0_out(register_0_out),
		.register_1_out(register_1_out),
		.syncing(regfile_syncing)
	);

	channel_file u_channel_file (
		.*,
		.clear(sweeping)
	);

	fetch_decode_stage #(.n_blocks(n_blocks)) u_fetch_decode (
		.*,
		.register_0_in(register_0_out),
		.register_1_in(register_1_out),
		.out_valid(dec_valid),
		.out_ready(dec_ready)
	);

	operand_fetch_stage u_operand_fetch (
		.*,
		.in_valid(dec_valid),
		.in_ready(dec_ready),
		.out_valid(issue_valid),
		.out_ready(issue_ready)
	);

	madd_pipeline #(.data_width(data_width)) u_madd (
		.*,
		.in_valid(issue_valid),
		.in_ready(issue_ready)
	);

endmodule

/* pipeline/madd_pipeline.sv */
module madd_pipeline #(
	parameter int data_width = dsp_cfg_pkg::DATA_W
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input dsp_cfg_pkg::sample_t arg_a,
	input dsp_cfg_pkg::sample_t arg_b,
	input dsp_cfg_pkg::sample_t arg_c,
	input dsp_cfg_pkg::chan_addr_t dest,
	input dsp_isa_pkg::shift_t shift,
	input logic sat_disable,
	output logic in_ready,
	output logic write_enable,
	output dsp_cfg_pkg::chan_addr_t write_addr,
	output dsp_cfg_pkg::sample_t write_val,
	output logic wb_done,
	output dsp_cfg_pkg::chan_addr_t wb_dest
);
	import dsp_cfg_pkg::*;
	import dsp_isa_pkg::*;

	localparam wide_t sat_max = (wide_t'(1) <<< (data_width - 1)) - wide_t'(1);
	localparam wide_t sat_min = -(wide_t'(1) <<< (data_width - 1));

	logic s1_valid;
	wide_t s1_product;
	sample_t s1_c;
	chan_addr_t s1_dest;
	shift_t s1_shift;
	logic s1_sat_disable;
	wide_t sum;
	wide_t clamped;

	// Write-back never stalls
	assign in_ready = 1'b1;
	assign wb_done = write_enable;
	assign wb_dest = write_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			write_enable <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			write_enable <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_product <= wide_t'(arg_a) * wide_t'(arg_b);
		s1_c <= arg_c;
		s1_dest <= dest;
		s1_shift <= shift;
		s1_sat_disable <= sat_disable;
	end

	always_comb begin
		sum = (s1_product >>> s1_shift) + wide_t'(s1_c);
		if (sum > sat_max) begin
			clamped = sat_max;
		end else if (sum < sat_min) begin
			clamped = sat_min;
		end else begin
			clamped = sum;
		end
	end

	always_ff @(posedge clk) begin
		write_addr <= s1_dest;
		write_val <= s1_sat_disable ? sample_t'(sum) : sample_t'(clamped);
	end

endmodule

/* pipeline/operand_fetch_stage.sv */
module operand_fetch_stage (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input dsp_cfg_pkg::chan_addr_t dec_src_a,
	input dsp_cfg_pkg::chan_addr_t dec_src_b,
	input dsp_cfg_pkg::chan_addr_t dec_src_c,
	input dsp_cfg_pkg::chan_addr_t dec_dest,
	input logic dec_a_is_reg,
	input logic dec_b_is_reg,
	input dsp_isa_pkg::shift_t dec_shift,
	input logic dec_sat_disable,
	input dsp_cfg_pkg::sample_t dec_register_0,
	input dsp_cfg_pkg::sample_t dec_register_1,
	input dsp_cfg_pkg::sample_t read_a,
	input dsp_cfg_pkg::sample_t read_b,
	input dsp_cfg_pkg::sample_t read_c,
	input logic out_ready,
	input logic wb_done,
	input dsp_cfg_pkg::chan_addr_t wb_dest,
	output logic in_ready,
	output dsp_cfg_pkg::chan_addr_t read_addr_a,
	output dsp_cfg_pkg::chan_addr_t read_addr_b,
	output dsp_cfg_pkg::chan_addr_t read_addr_c,
	output logic out_valid,
	output dsp_cfg_pkg::sample_t arg_a,
	output dsp_cfg_pkg::sample_t arg_b,
	output dsp_cfg_pkg::sample_t arg_c,
	output dsp_cfg_pkg::chan_addr_t dest,
	output dsp_isa_pkg::shift_t shift,
	output logic sat_disable
);
	import dsp_cfg_pkg::*;

	logic [N_CHANNELS-1:0] pending;
	logic [N_CHANNELS-1:0] set_mask;
	logic [N_CHANNELS-1:0] clear_mask;
	logic hazard;
	logic capture;

	assign read_addr_a = dec_src_a;
	assign read_addr_b = dec_src_b;
	assign read_addr_c = dec_src_c;

	// A pending dest also stalls, since one pending bit cannot count two writers
	assign hazard = (pending[dec_src_a] && !dec_a_is_reg)
		|| (pending[dec_src_b] && !dec_b_is_reg)
		|| pending[dec_src_c]
		|| pending[dec_dest];
	assign in_ready = !hazard && (!out_valid || out_ready);
	assign capture = in_valid && in_ready;

	assign set_mask = capture ? (N_CHANNELS'(1) << dec_dest) : '0;
	assign clear_mask = wb_done ? (N_CHANNELS'(1) << wb_dest) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			pending <= '0;
		end else begin
			pending <= (pending & ~clear_mask) | set_mask;
			if (capture) begin
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			arg_a <= dec_a_is_reg ? dec_register_0 : read_a;
			arg_b <= dec_b_is_reg ? dec_register_1 : read_b;
			arg_c <= read_c;
			dest <= dec_dest;
			shift <= dec_shift;
			sat_disable <= dec_sat_disable;
		end
	end

endmodule

/* pipeline/fetch_decode_stage.sv */
module fetch_decode_stage #(
	parameter int n_blocks = dsp_cfg_pkg::N_BLOCKS_DEF,
	localparam type block_addr_t = logic [$clog2(n_blocks)-1:0],
	localparam type block_count_t = logic [$clog2(n_blocks):0]
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input block_count_t n_blocks_running,
	input dsp_cfg_pkg::instr_t instr_read_val,
	input dsp_cfg_pkg::sample_t register_0_in,
	input dsp_cfg_pkg::sample_t register_1_in,
	input logic wb_done,
	input logic out_ready,
	output block_addr_t block_read_addr,
	output logic out_valid,
	output logic busy,
	output dsp_cfg_pkg::chan_addr_t dec_src_a,
	output dsp_cfg_pkg::chan_addr_t dec_src_b,
	output dsp_cfg_pkg::chan_addr_t dec_src_c,
	output dsp_cfg_pkg::chan_addr_t dec_dest,
	output logic dec_a_is_reg,
	output logic dec_b_is_reg,
	output dsp_isa_pkg::shift_t dec_shift,
	output logic dec_sat_disable,
	output dsp_cfg_pkg::sample_t dec_register_0,
	output dsp_cfg_pkg::sample_t dec_register_1
);
	import dsp_isa_pkg::*;

	seq_state_e state;
	block_addr_t cur_addr;
	logic [2:0] in_flight;
	logic take;
	logic last_block;
	logic start;

	assign take = out_valid && out_ready;
	assign last_block = (cur_addr == block_addr_t'(n_blocks_running - 1'b1));
	assign out_valid = (state == SEQ_RUN);
	assign busy = (state == SEQ_RUN) || (in_flight != '0);
	assign start = tick && !busy && (n_blocks_running != '0);

	// The memories answer one cycle late, so the address leads cur_addr by one edge
	always_comb begin
		if (state == SEQ_IDLE || (take && last_block)) begin
			block_read_addr = '0;
		end else if (take) begin
			block_read_addr = cur_addr + 1'b1;
		end else begin
			block_read_addr = cur_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			cur_addr <= '0;
			in_flight <= '0;
		end else begin
			cur_addr <= block_read_addr;
			case (state)
				SEQ_IDLE: begin
					if (start) begin
						state <= SEQ_RUN;
					end
				end
				SEQ_RUN: begin
					if (take && last_block) begin
						state <= SEQ_IDLE;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
			// Blocks handed on but not yet written back
			if (take && !wb_done) begin
				in_flight <= in_flight + 1'b1;
			end else if (!take && wb_done) begin
				in_flight <= in_flight - 1'b1;
			end
		end
	end

	assign dec_src_a = instr_read_val[SRC_A_LSB +: CHAN_FIELD_W];
	assign dec_src_b = instr_read_val[SRC_B_LSB +: CHAN_FIELD_W];
	assign dec_src_c = instr_read_val[SRC_C_LSB +: CHAN_FIELD_W];
	assign dec_dest = instr_read_val[DEST_LSB +: CHAN_FIELD_W];
	assign dec_a_is_reg = instr_read_val[A_IS_REG_BIT];
	assign dec_b_is_reg = instr_read_val[B_IS_REG_BIT];
	assign dec_shift = instr_read_val[SHIFT_LSB +: SHIFT_W];
	assign dec_sat_disable = instr_read_val[SAT_DISABLE_BIT];
	assign dec_register_0 = register_0_in;
	assign dec_register_1 = register_1_in;

endmodule

/* rtl/channel_file.sv */
module channel_file (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic tick,
	input dsp_cfg_pkg::sample_t sample_in,
	input dsp_cfg_pkg::chan_addr_t read_addr_a,
	input dsp_cfg_pkg::chan_addr_t read_addr_b,
	input dsp_cfg_pkg::chan_addr_t read_addr_c,
	input logic write_enable,
	input dsp_cfg_pkg::chan_addr_t write_addr,
	input dsp_cfg_pkg::sample_t write_val,
	output dsp_cfg_pkg::sample_t read_a,
	output dsp_cfg_pkg::sample_t read_b,
	output dsp_cfg_pkg::sample_t read_c,
	output dsp_cfg_pkg::sample_t sample_out
);
	import dsp_cfg_pkg::*;

	sample_t channels [N_CHANNELS];

	assign read_a = channels[read_addr_a];
	assign read_b = channels[read_addr_b];
	assign read_c = channels[read_addr_c];

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			for (int i = 0; i < N_CHANNELS; i++) begin
				channels[i] <= '0;
			end
		end else begin
			if (write_enable) begin
				channels[write_addr] <= write_val;
			end
			// Sample exchange wins over a write-back to channel 0
			if (tick) begin
				channels[0] <= sample_in;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_out <= '0;
		end else if (tick) begin
			sample_out <= channels[0];
		end
	end

endmodule

/* rtl/block_regfile.sv */
module block_regfile #(
	parameter int n_blocks = dsp_cfg_pkg::N_BLOCKS_DEF,
	localparam type block_addr_t = logic [$clog2(n_blocks)-1:0],
	localparam type block_count_t = logic [$clog2(n_blocks):0]
) (
	input logic clk,
	input logic reset,
	input block_count_t n_active_blocks,
	input block_addr_t read_addr,
	input block_addr_t write_addr,
	input logic write_select,
	input dsp_cfg_pkg::sample_t write_value,
	input logic write_enable,
	input logic commit,
	output dsp_cfg_pkg::sample_t register_0_out,
	output dsp_cfg_pkg::sample_t register_1_out,
	output logic syncing
);
	import dsp_cfg_pkg::*;

	// Indexed by bank, register select, block
	sample_t regs [2][2][n_blocks];
	logic active;
	logic shadow;
	block_addr_t sync_ctr;

	assign shadow = ~active;

	always_ff @(posedge clk) begin
		register_0_out <= regs[active][0][read_addr];
		register_1_out <= regs[active][1][read_addr];
		if (syncing) begin
			// Bring the old bank up to the committed values
			regs[shadow][0][sync_ctr] <= regs[active][0][sync_ctr];
			regs[shadow][1][sync_ctr] <= regs[active][1][sync_ctr];
		end else if (write_enable) begin
			regs[shadow][write_select][write_addr] <= write_value;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			syncing <= 1'b0;
			sync_ctr <= '0;
		end else if (commit) begin
			active <= ~active;
			sync_ctr <= '0;
			syncing <= (n_active_blocks != '0);
		end else if (syncing) begin
			sync_ctr <= sync_ctr + 1'b1;
			if (block_count_t'(sync_ctr) + 1'b1 == n_active_blocks) begin
				syncing <= 1'b0;
			end
		end
	end

endmodule

/* rtl/block_store.sv */
module block_store #(
	parameter int n_blocks = dsp_cfg_pkg::N_BLOCKS_DEF,
	localparam type block_addr_t = logic [$clog2(n_blocks)-1:0],
	localparam type block_count_t = logic [$clog2(n_blocks):0]
) (
	input logic clk,
	input logic reset,
	input logic full_reset,
	input logic instr_write,
	input block_addr_t write_addr,
	input dsp_cfg_pkg::instr_t write_val,
	input block_addr_t read_addr,
	output dsp_cfg_pkg::instr_t read_val,
	output block_count_t n_blocks_running,
	output logic ready,
	output logic sweeping
);
	import dsp_cfg_pkg::*;

	instr_t instrs [n_blocks];
	block_addr_t sweep_ctr;

	assign ready = !sweeping;

	always_ff @(posedge clk) begin
		read_val <= instrs[read_addr];
		if (sweeping) begin
			instrs[sweep_ctr] <= '0;
		end else if (instr_write) begin
			instrs[write_addr] <= write_val;
		end
	end

	// Sweep runs one entry per cycle, so ready is low for n_blocks cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			sweeping <= 1'b0;
			sweep_ctr <= '0;
			n_blocks_running <= '0;
		end else if (full_reset) begin
			sweeping <= 1'b1;
			sweep_ctr <= '0;
			n_blocks_running <= '0;
		end else if (sweeping) begin
			sweep_ctr <= sweep_ctr + 1'b1;
			if (sweep_ctr == block_addr_t'(n_blocks - 1)) begin
				sweeping <= 1'b0;
			end
		end else if (instr_write && block_count_t'(write_addr) >= n_blocks_running) begin
			// Track the highest block written plus one
			n_blocks_running <= block_count_t'(write_addr) + 1'b1;
		end
	end

endmodule

/* common/dsp_isa_pkg.sv */
package dsp_isa_pkg;

	localparam int CHAN_FIELD_W = 4;
	localparam int SHIFT_W = 5;

	// Bit positions within an instruction word
	localparam int SRC_A_LSB = 0;
	localparam int SRC_B_LSB = 4;
	localparam int SRC_C_LSB = 8;
	localparam int DEST_LSB = 12;
	localparam int A_IS_REG_BIT = 16;
	localparam int B_IS_REG_BIT = 17;
	localparam int SHIFT_LSB = 18;
	localparam int SAT_DISABLE_BIT = 23;

	// Bits 24 to 31 carry nothing

	typedef logic [SHIFT_W-1:0] shift_t;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_e;

endpackage

/* common/dsp_cfg_pkg.sv */
package dsp_cfg_pkg;

	localparam int DATA_W = 16;
	localparam int N_BLOCKS_DEF = 256;
	localparam int N_CHANNELS = 16;
	localparam int CHAN_ADDR_W = $clog2(N_CHANNELS);

	// Full product plus headroom for the shift and the added operand
	localparam int FULL_W = 2 * DATA_W + 8;

	typedef logic signed [DATA_W-1:0] sample_t;
	typedef logic signed [FULL_W-1:0] wide_t;
	typedef logic [CHAN_ADDR_W-1:0] chan_addr_t;
	typedef logic [31:0] instr_t;

endpackage
